// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := lane_pack_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: logic/lane_compact_execute.sv
// Lane compaction mux

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_compact_execute
  import lane_pack_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        dec_valid,
  input  lane_idx_t [`NUM_LANES-1:0] dec_sel,
  input  lane_cnt_t                  dec_cnt,
  input  lane_t [`NUM_LANES-1:0]     dec_data,
  output logic                       exe_valid,
  output lane_t [`NUM_LANES-1:0]     exe_data,
  output lane_cnt_t                  exe_cnt,
  output lane_cnt_t                  beat_valid_cnt
);

  lane_t [`NUM_LANES-1:0] packed_data;

  //////////////////////////////////////////////////
  // Packed order mux
  //////////////////////////////////////////////////

  // Positions at or above dec_cnt carry stale lanes that the buffer ignores
  always_comb begin
    for (int j = 0; j < `NUM_LANES; j++) begin
      packed_data[j] = dec_data[dec_sel[j]];
    end
  end

  always_ff @(posedge clk) begin
    exe_data <= packed_data;
  end

  //////////////////////////////////////////////////
  // Valid and lane count
  //////////////////////////////////////////////////

  // Idle cycles carry a zero count
  always_ff @(posedge clk) begin
    if (reset) begin
      exe_valid <= 1'b0;
      exe_cnt   <= '0;
    end else begin
      exe_valid <= dec_valid;
      exe_cnt   <= dec_valid ? dec_cnt : '0;
    end
  end

  // Same count feeds the lane statistics
  assign beat_valid_cnt = exe_cnt;

endmodule

`default_nettype wire

// File: logic/lane_count_decode.sv
// Lane count decode

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_count_decode
  import lane_pack_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        enable,
  input  lane_t [`NUM_LANES-1:0]     in_data,
  input  wire   [`NUM_LANES-1:0]     in_holes,
  input  wire                        in_valid,
  output logic                       dec_valid,
  output lane_idx_t [`NUM_LANES-1:0] dec_sel,
  output lane_cnt_t                  dec_cnt,
  output lane_t [`NUM_LANES-1:0]     dec_data
);

  logic                       valid_s1;
  logic [`NUM_LANES-1:0]      holes_s1;
  lane_t [`NUM_LANES-1:0]     data_s1;
  lane_cnt_t [`NUM_LANES-1:0] prefix_cnt;
  lane_cnt_t [`NUM_LANES-1:0] prefix_cnt_s2;

  // Beats only count while the block is enabled
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_s1  <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      valid_s1  <= in_valid & enable;
      dec_valid <= valid_s1;
    end
  end

  always_ff @(posedge clk) begin
    holes_s1      <= in_holes;
    data_s1       <= in_data;
    dec_data      <= data_s1;
    prefix_cnt_s2 <= prefix_cnt;
  end

  //////////////////////////////////////////////////
  // Running count of valid lanes up to each lane
  //////////////////////////////////////////////////

  always_comb begin
    lane_cnt_t run;
    run = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      run = run + lane_cnt_t'(!holes_s1[i]);
      prefix_cnt[i] = run;
    end
  end

  // Packed position j takes the first lane whose count reaches j+1
  always_comb begin
    logic found;
    for (int j = 0; j < `NUM_LANES; j++) begin
      dec_sel[j] = '0;
      found      = 1'b0;
      for (int k = 0; k < `NUM_LANES; k++) begin
        if (!found && prefix_cnt_s2[k] == lane_cnt_t'(j + 1)) begin
          found      = 1'b1;
          dec_sel[j] = lane_idx_t'(k);
        end
      end
    end
  end

  assign dec_cnt = prefix_cnt_s2[`NUM_LANES-1];

endmodule

`default_nettype wire

// File: logic/lane_pack_macros.svh
// Lane packing parameters

`ifndef LANE_PACK_MACROS_SVH
`define LANE_PACK_MACROS_SVH

//////////////////////////////////////////////////
// Data path geometry
//////////////////////////////////////////////////

// Bits per lane word
`define LANE_WIDTH 16

// Lanes per input and output beat
`define NUM_LANES 4

//////////////////////////////////////////////////
// Control path
//////////////////////////////////////////////////

`define APB_ADDR_WIDTH 4

`endif

// File: logic/lane_pack_pkg.sv
// Lane packing types

`default_nettype none

`include "lane_pack_macros.svh"

package lane_pack_pkg;

  // One lane word
  typedef logic [`LANE_WIDTH-1:0] lane_t;

  // Number of valid lanes in a beat, 0 to NUM_LANES
  typedef logic [$clog2(`NUM_LANES+1)-1:0] lane_cnt_t;

  // Index of one lane within a beat
  typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

  //////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////

  typedef enum logic [`APB_ADDR_WIDTH-1:0] {
    REG_CTRL      = 'h0,
    REG_LANES_IN  = 'h4,
    REG_BEATS_OUT = 'h8,
    REG_ID        = 'hC
  } reg_addr_e;

endpackage

`default_nettype wire

// File: logic/lane_pack_regs.sv
// APB control registers

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_pack_regs
  import lane_pack_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [`APB_ADDR_WIDTH-1:0]  paddr,
  input  wire [31:0]                 pwdata,
  input  lane_cnt_t                  beat_valid_cnt,
  input  wire                        out_valid,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       enable
);

  localparam logic [31:0] ID_VALUE = 32'h4C50_0001;

  logic        setup_phase;
  logic        wr_access;
  logic        addr_hit;
  logic        cnt_clear;
  logic [31:0] rd_value;
  logic [31:0] lanes_in_cnt;
  logic [31:0] beats_out_cnt;

  // No wait states
  assign pready = 1'b1;

  assign setup_phase = psel & ~penable;
  assign wr_access   = psel & penable & pwrite;

  //////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////

  always_comb begin
    addr_hit = 1'b1;
    rd_value = '0;
    case (reg_addr_e'(paddr))
      REG_CTRL:      rd_value = {31'b0, enable};
      REG_LANES_IN:  rd_value = lanes_in_cnt;
      REG_BEATS_OUT: rd_value = beats_out_cnt;
      REG_ID:        rd_value = ID_VALUE;
      default:       addr_hit = 1'b0;
    endcase
  end

  // Response is captured in setup and presented in the access phase
  always_ff @(posedge clk) begin
    if (reset) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      prdata  <= (setup_phase && !pwrite) ? rd_value : '0;
      pslverr <= setup_phase & ~addr_hit;
    end
  end

  //////////////////////////////////////////////////
  // Control and statistics
  //////////////////////////////////////////////////

  assign cnt_clear = wr_access && reg_addr_e'(paddr) == REG_CTRL && pwdata[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      enable        <= 1'b0;
      lanes_in_cnt  <= '0;
      beats_out_cnt <= '0;
    end else begin
      if (wr_access && reg_addr_e'(paddr) == REG_CTRL) begin
        enable <= pwdata[0];
      end
      // Clear wins over a same-cycle update
      if (cnt_clear) begin
        lanes_in_cnt  <= '0;
        beats_out_cnt <= '0;
      end else begin
        lanes_in_cnt  <= lanes_in_cnt + 32'(beat_valid_cnt);
        beats_out_cnt <= beats_out_cnt + 32'(out_valid);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/lane_pack_top.sv
// Lane packing top level

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_pack_top
  import lane_pack_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  lane_t [`NUM_LANES-1:0]     in_data,
  input  wire   [`NUM_LANES-1:0]     in_holes,
  input  wire                        in_valid,
  output lane_t [`NUM_LANES-1:0]     out_data,
  output logic                       out_valid,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [`APB_ADDR_WIDTH-1:0]  paddr,
  input  wire [31:0]                 pwdata,
  output logic [31:0]                prdata,
  output logic                       pready,
  output logic                       pslverr
);

  logic                       enable;
  logic                       dec_valid;
  lane_idx_t [`NUM_LANES-1:0] dec_sel;
  lane_cnt_t                  dec_cnt;
  lane_t [`NUM_LANES-1:0]     dec_data;
  logic                       exe_valid;
  lane_t [`NUM_LANES-1:0]     exe_data;
  lane_cnt_t                  exe_cnt;
  lane_cnt_t                  beat_valid_cnt;

  //////////////////////////////////////////////////
  // Control path
  //////////////////////////////////////////////////

  lane_pack_regs u_regs (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .beat_valid_cnt(beat_valid_cnt), .out_valid(out_valid),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .enable(enable)
  );

  //////////////////////////////////////////////////
  // Data path from decode through mux to gather
  //////////////////////////////////////////////////

  lane_count_decode u_decode (
    .clk(clk), .reset(reset), .enable(enable),
    .in_data(in_data), .in_holes(in_holes), .in_valid(in_valid),
    .dec_valid(dec_valid), .dec_sel(dec_sel), .dec_cnt(dec_cnt), .dec_data(dec_data)
  );

  lane_compact_execute u_execute (
    .clk(clk), .reset(reset),
    .dec_valid(dec_valid), .dec_sel(dec_sel), .dec_cnt(dec_cnt), .dec_data(dec_data),
    .exe_valid(exe_valid), .exe_data(exe_data), .exe_cnt(exe_cnt),
    .beat_valid_cnt(beat_valid_cnt)
  );

  pack_result_buffer u_buffer (
    .clk(clk), .reset(reset),
    .exe_valid(exe_valid), .exe_data(exe_data), .exe_cnt(exe_cnt),
    .out_data(out_data), .out_valid(out_valid)
  );

endmodule

`default_nettype wire

// File: logic/pack_result_buffer.sv
// Packed word buffer

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module pack_result_buffer
  import lane_pack_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        exe_valid,
  input  lane_t [`NUM_LANES-1:0]     exe_data,
  input  lane_cnt_t                  exe_cnt,
  output lane_t [`NUM_LANES-1:0]     out_data,
  output logic                       out_valid
);

  // Three beats of words
  localparam int DEPTH = 3 * `NUM_LANES;

  typedef logic [$clog2(DEPTH+1)-1:0] buf_cnt_t;

  lane_t [DEPTH-1:0] store;
  lane_t [DEPTH-1:0] kept_words;
  lane_t [DEPTH-1:0] next_store;
  buf_cnt_t          stored_cnt;
  buf_cnt_t          kept_cnt;
  buf_cnt_t          next_cnt;

  //////////////////////////////////////////////////
  // Shift out, then append
  //////////////////////////////////////////////////

  // Front beat leaves while out_valid is high
  assign kept_cnt   = stored_cnt - (out_valid ? buf_cnt_t'(`NUM_LANES) : '0);
  assign kept_words = out_valid ? (store >> (`NUM_LANES * `LANE_WIDTH)) : store;

  assign next_cnt = kept_cnt + (exe_valid ? buf_cnt_t'(exe_cnt) : '0);

  // New words land right behind the ones kept
  always_comb begin
    buf_cnt_t off;
    for (int i = 0; i < DEPTH; i++) begin
      off = buf_cnt_t'(i) - kept_cnt;
      if (buf_cnt_t'(i) < kept_cnt || off >= buf_cnt_t'(`NUM_LANES)) begin
        next_store[i] = kept_words[i];
      end else begin
        next_store[i] = exe_data[lane_idx_t'(off)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stored_cnt <= '0;
      out_valid  <= 1'b0;
    end else begin
      stored_cnt <= next_cnt;
      out_valid  <= next_cnt >= buf_cnt_t'(`NUM_LANES);
    end
  end

  always_ff @(posedge clk) begin
    store <= next_store;
  end

  // Oldest word sits in lane 0
  assign out_data = store[`NUM_LANES-1:0];

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/lane_pack_pkg.sv
logic/lane_count_decode.sv
logic/lane_compact_execute.sv
logic/pack_result_buffer.sv
logic/lane_pack_regs.sv
logic/lane_pack_top.sv
tb/lane_pack_checker.sv
tb/lane_pack_tb.sv

// File: tb/lane_pack_checker.sv
// Lane packing interface checks

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_pack_checker
  import lane_pack_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pready,
  input  wire                    pslverr,
  input  wire                    out_valid,
  input  lane_t [`NUM_LANES-1:0] out_data
);

  // APB slave never inserts wait states
  pready_high: assert property (@(posedge clk) pready)
    else $error("pready went low");

  // No output beat while reset is applied
  no_output_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high during reset");

  out_data_known: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> !$isunknown(out_data))
    else $error("out_data has unknown bits while out_valid is high");

  // Error response only in the access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (reset)
    pslverr |-> psel && penable)
    else $error("pslverr high outside an APB access phase");

endmodule

bind lane_pack_top lane_pack_checker u_checker (
  .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
  .pslverr(pslverr), .out_valid(out_valid), .out_data(out_data)
);

`default_nettype wire

// File: tb/lane_pack_tb.sv
// Lane packing testbench

`timescale 1ns/1ns
`default_nettype none

`include "lane_pack_macros.svh"

module lane_pack_tb
  import lane_pack_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int FULL_BEATS      = 16;
  localparam int RAND_BEATS      = 60;
  localparam int OFF_BEATS       = 10;
  localparam int WATCHDOG_CYCLES = (FULL_BEATS + RAND_BEATS + OFF_BEATS) * 10 + 200;

  typedef lane_t [`NUM_LANES-1:0] beat_t;

  logic                       clk;
  logic                       reset;
  beat_t                      in_data;
  logic [`NUM_LANES-1:0]      in_holes;
  logic                       in_valid;
  beat_t                      out_data;
  logic                       out_valid;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`APB_ADDR_WIDTH-1:0] paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;

  logic [31:0] rng_state;
  logic        enabled;
  int          lanes_accepted;
  int          beats_seen;
  lane_t       model_words[$];
  beat_t       expected_beats[$];

  lane_pack_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Non-hole lanes queue up in lane order and every four words form a beat
  function automatic void model_beat(input beat_t data, input logic [`NUM_LANES-1:0] holes);
    beat_t beat;
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (!holes[i]) begin
        model_words.push_back(data[i]);
        lanes_accepted++;
      end
    end
    while (model_words.size() >= `NUM_LANES) begin
      for (int j = 0; j < `NUM_LANES; j++) begin
        beat[j] = model_words.pop_front();
      end
      expected_beats.push_back(beat);
    end
  endfunction

  always @(negedge clk) begin
    beat_t exp_beat;
    if (!reset && out_valid) begin
      assert (expected_beats.size() != 0)
        else fail_now("output beat arrived while no expected beat was pending");
      exp_beat = expected_beats.pop_front();
      assert (out_data == exp_beat)
        else fail_now($sformatf("FAIL out_data=%h expected=%h", out_data, exp_beat));
      beats_seen++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Reads compare prdata with value unless an error response is expected
  task automatic apb_access(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] value, input logic expect_err);
    logic [31:0] rdata;
    logic        err;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = value;
    @(negedge clk);
    penable = 1'b1;
    rdata   = prdata;
    err     = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    assert (err == expect_err)
      else fail_now($sformatf("FAIL pslverr=%h expected=%h at paddr=%h", err, expect_err, addr));
    assert (write || expect_err || rdata == value)
      else fail_now($sformatf("FAIL prdata=%h expected=%h at paddr=%h", rdata, value, addr));
  endtask

  task automatic drive_beats(input int count, input bit with_holes);
    logic [31:0]           r;
    logic [`NUM_LANES-1:0] holes;
    for (int n = 0; n < count; n++) begin
      r     = next_random();
      holes = with_holes ? ((n % 5 == 4) ? '1 : r[`NUM_LANES-1:0]) : '0;
      // Occasional idle cycle between beats
      if (with_holes && r[8]) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      @(negedge clk);
      in_data  = {next_random(), r};
      in_holes = holes;
      in_valid = 1'b1;
      if (enabled) begin
        model_beat(in_data, holes);
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expected_beats.size() != 0) begin
      @(negedge clk);
    end
    // Let the pipeline settle
    repeat (8) @(negedge clk);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_now("timeout: the run did not finish in the allowed number of cycles");
  end

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    in_data        = '0;
    in_holes       = '0;
    in_valid       = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    rng_state      = 32'he39c_42ab;
    enabled        = 1'b0;
    lanes_accepted = 0;
    beats_seen     = 0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    apb_access(1'b0, REG_ID, 32'h4C50_0001, 1'b0);
    apb_access(1'b1, REG_CTRL, 32'h1, 1'b0);
    enabled = 1'b1;
    apb_access(1'b0, REG_CTRL, 32'h1, 1'b0);

    // Full beats, then random holes with all-hole beats mixed in
    drive_beats(FULL_BEATS, 1'b0);
    wait_drain();
    drive_beats(RAND_BEATS, 1'b1);
    wait_drain();

    // Beats while disabled are dropped
    apb_access(1'b1, REG_CTRL, 32'h0, 1'b0);
    enabled = 1'b0;
    drive_beats(OFF_BEATS, 1'b1);
    wait_drain();

    apb_access(1'b0, REG_LANES_IN, 32'(lanes_accepted), 1'b0);
    apb_access(1'b0, REG_BEATS_OUT, 32'(beats_seen), 1'b0);
    apb_access(1'b1, REG_CTRL, 32'h2, 1'b0);
    apb_access(1'b0, REG_LANES_IN, 32'h0, 1'b0);
    apb_access(1'b0, REG_BEATS_OUT, 32'h0, 1'b0);

    // Unmapped offsets answer with an error and leave the control bits alone
    apb_access(1'b1, 4'h6, 32'h3, 1'b1);
    apb_access(1'b0, 4'hE, 32'h0, 1'b1);
    apb_access(1'b0, REG_CTRL, 32'h0, 1'b0);

    if (expected_beats.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_now($sformatf("%0d expected beats were never produced", expected_beats.size()));
    end
  end

endmodule

`default_nettype wire
